/* run_sim.sh */
#!/bin/sh
# build and run the fetch front testbench with Verilator, result taken from sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_fetch_front \
	-o sim_fetch_front > build.log 2>&1 &&
	./obj_dir/sim_fetch_front > sim.log 2>&1 ||
	{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log && echo "test passed" ||
	{ echo "test failed, see sim.log"; exit 1; }

/* src/branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic [fetch_pkg::ADDR_W-1:0] lookup_pc,
	input  logic                         upd_valid,
	input  fetch_pkg::npc_op_t           upd_op,
	input  logic [fetch_pkg::ADDR_W-1:0] upd_pc,
	input  logic                         upd_taken,
	input  logic [fetch_pkg::ADDR_W-1:0] upd_target,
	output logic                         pred_taken,
	output logic [fetch_pkg::ADDR_W-1:0] pred_target
);

	import fetch_pkg::*;

	logic [1:0]           bht_cnt    [BHT_ENTRIES];
	logic [BHT_ENTRIES-1:0] btb_valid;
	logic [BTB_TAG_W-1:0] btb_tag    [BHT_ENTRIES];
	logic [ADDR_W-1:0]    btb_target [BHT_ENTRIES];

	logic [BHT_IDX_W-1:0] lk_idx;
	logic [BTB_TAG_W-1:0] lk_tag;
	logic [BHT_IDX_W-1:0] up_idx;
	logic [BTB_TAG_W-1:0] up_tag;
	logic                 up_en;
	logic                 up_dir;
	logic                 btb_hit;

	// **********************************************************************
	// lookup
	// **********************************************************************
	assign lk_idx  = lookup_pc[IDX_LO +: BHT_IDX_W];
	assign lk_tag  = lookup_pc[TAG_LO +: BTB_TAG_W];
	assign btb_hit = btb_valid[lk_idx] && (btb_tag[lk_idx] == lk_tag);

	assign pred_taken  = btb_hit && bht_cnt[lk_idx][1];    // strong or weak taken
	assign pred_target = btb_target[lk_idx];

	// **********************************************************************
	// update on resolve
	// **********************************************************************
	assign up_idx = upd_pc[IDX_LO +: BHT_IDX_W];
	assign up_tag = upd_pc[TAG_LO +: BTB_TAG_W];
	assign up_en  = upd_valid && ((upd_op == OP_BRANCH) || (upd_op == OP_JUMP));
	// a jump always trains toward taken
	assign up_dir = upd_taken || (upd_op == OP_JUMP);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < BHT_ENTRIES; i++) begin
				bht_cnt[i] <= CNT_INIT;
			end
			btb_valid <= '0;
		end else if (up_en) begin
			if (up_dir && bht_cnt[up_idx] != 2'b11) begin
				bht_cnt[up_idx] <= bht_cnt[up_idx] + 2'd1;
			end else if (!up_dir && bht_cnt[up_idx] != 2'b00) begin
				bht_cnt[up_idx] <= bht_cnt[up_idx] - 2'd1;
			end
			if (up_dir) begin
				btb_valid[up_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (up_en && up_dir) begin
			btb_tag[up_idx]    <= up_tag;
			btb_target[up_idx] <= upd_target;
		end
	end

endmodule

`default_nettype wire

/* src/fetch_front.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_front (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         resolve_valid,
	input  fetch_pkg::npc_op_t           resolve_op,
	input  logic [fetch_pkg::ADDR_W-1:0] resolve_pc,
	input  logic                         resolve_taken,
	input  logic [fetch_pkg::ADDR_W-1:0] resolve_target,
	input  logic                         resolve_predicted,
	input  logic [fetch_pkg::ADDR_W-1:0] resolve_pred_target,
	input  logic                         exc,
	input  logic                         eret,
	input  logic [fetch_pkg::ADDR_W-1:0] epc,
	input  logic                         can_go,
	input  logic                         stall,
	output logic [fetch_pkg::ADDR_W-1:0] fetch_pc,
	output logic                         fetch_predict,
	output logic                         pf_flush,
	output logic                         if_flush,
	output logic                         id_flush,
	output logic                         ex_flush,
	output logic                         mem1_flush
);

	import fetch_pkg::*;

	logic [ADDR_W-1:0] seq_pc;
	logic              pred_taken;
	logic [ADDR_W-1:0] pred_target;
	logic [ADDR_W-1:0] next_pc;
	logic              next_predict;

	branch_predictor u_bp (
		.clk         (clk),
		.arst_n      (arst_n),
		.lookup_pc   (fetch_pc),
		.upd_valid   (resolve_valid),
		.upd_op      (resolve_op),
		.upd_pc      (resolve_pc),
		.upd_taken   (resolve_taken),
		.upd_target  (resolve_target),
		.pred_taken  (pred_taken),
		.pred_target (pred_target)
	);

	next_pc_sel u_npc (
		.resolve_valid       (resolve_valid),
		.resolve_op          (resolve_op),
		.resolve_pc          (resolve_pc),
		.resolve_taken       (resolve_taken),
		.resolve_target      (resolve_target),
		.resolve_predicted   (resolve_predicted),
		.resolve_pred_target (resolve_pred_target),
		.exc                 (exc),
		.eret                (eret),
		.epc                 (epc),
		.pred_taken          (pred_taken),
		.pred_target         (pred_target),
		.seq_pc              (seq_pc),
		.next_pc             (next_pc),
		.next_predict        (next_predict),
		.redirect            (),
		.pf_flush            (pf_flush)
	);

	flush_ctrl u_flush (
		.clk        (clk),
		.arst_n     (arst_n),
		.exc        (exc),
		.eret       (eret),
		.can_go     (can_go),
		.if_flush   (if_flush),
		.id_flush   (id_flush),
		.ex_flush   (ex_flush),
		.mem1_flush (mem1_flush)
	);

	pc_gen u_pc (
		.clk           (clk),
		.arst_n        (arst_n),
		.stall         (stall),
		.force_load    (pf_flush),
		.next_pc       (next_pc),
		.next_predict  (next_predict),
		.fetch_pc      (fetch_pc),
		.fetch_predict (fetch_predict),
		.seq_pc        (seq_pc)
	);

endmodule

`default_nettype wire

/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	// **********************************************************************
	// address and table geometry
	// **********************************************************************
	localparam int ADDR_W      = 32;
	localparam int WORD_OFS_W  = 2;                        // byte offset in a word
	localparam int BHT_IDX_W   = 6;
	localparam int BHT_ENTRIES = 1 << BHT_IDX_W;           // 64 entries
	localparam int BTB_TAG_W   = ADDR_W - BHT_IDX_W - WORD_OFS_W;
	localparam int IDX_LO      = WORD_OFS_W;
	localparam int TAG_LO      = WORD_OFS_W + BHT_IDX_W;

	// **********************************************************************
	// resolved instruction kind
	// **********************************************************************
	typedef enum logic [1:0] {
		OP_SEQ    = 2'b00,                                 // no control transfer
		OP_BRANCH = 2'b01,
		OP_JUMP   = 2'b10,
		OP_RETURN = 2'b11                                  // jr, no return stack
	} npc_op_t;

	// **********************************************************************
	// fixed addresses and counter state
	// **********************************************************************
	localparam logic [ADDR_W-1:0] RESET_PC   = 32'hBFC0_0000;
	localparam logic [ADDR_W-1:0] EXC_VECTOR = 32'hBFC0_0380;
	localparam logic [ADDR_W-1:0] PC_STEP    = 32'd4;
	localparam logic [ADDR_W-1:0] SLOT_SKIP  = 32'd8;   // past the delay slot

	localparam logic [1:0] CNT_INIT = 2'b01;               // weakly not-taken

endpackage

`default_nettype wire

/* src/flush_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module flush_ctrl (
	input  logic clk,
	input  logic arst_n,
	input  logic exc,
	input  logic eret,
	input  logic can_go,
	output logic if_flush,
	output logic id_flush,
	output logic ex_flush,
	output logic mem1_flush
);

	logic exc_any;
	logic mem1_pending;

	assign exc_any = exc || eret;

	assign if_flush = exc_any;
	assign id_flush = exc_any;
	assign ex_flush = exc_any;

	// memory stage only flushes once it may advance
	assign mem1_flush = (exc_any || mem1_pending) && can_go;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem1_pending <= 1'b0;
		end else if (can_go) begin
			mem1_pending <= 1'b0;                          // served this cycle
		end else if (exc_any) begin
			mem1_pending <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/next_pc_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module next_pc_sel (
	input  logic                         resolve_valid,
	input  fetch_pkg::npc_op_t           resolve_op,
	input  logic [fetch_pkg::ADDR_W-1:0] resolve_pc,
	input  logic                         resolve_taken,
	input  logic [fetch_pkg::ADDR_W-1:0] resolve_target,
	input  logic                         resolve_predicted,
	input  logic [fetch_pkg::ADDR_W-1:0] resolve_pred_target,
	input  logic                         exc,
	input  logic                         eret,
	input  logic [fetch_pkg::ADDR_W-1:0] epc,
	input  logic                         pred_taken,
	input  logic [fetch_pkg::ADDR_W-1:0] pred_target,
	input  logic [fetch_pkg::ADDR_W-1:0] seq_pc,
	output logic [fetch_pkg::ADDR_W-1:0] next_pc,
	output logic                         next_predict,
	output logic                         redirect,
	output logic                         pf_flush
);

	import fetch_pkg::*;

	logic              tgt_differs;
	logic              flush_seq;
	logic              flush_br;
	logic              flush_jmp;
	logic              flush_sel;
	logic [ADDR_W-1:0] fall_thru;
	logic [ADDR_W-1:0] redir_pc;

	assign tgt_differs = (resolve_target != resolve_pred_target);
	assign fall_thru   = resolve_pc + SLOT_SKIP;

	// per-op mispredict conditions
	assign flush_seq = resolve_predicted;
	assign flush_br  = (resolve_taken != resolve_predicted) ||
		(resolve_taken && resolve_predicted && tgt_differs);
	assign flush_jmp = !resolve_predicted || tgt_differs;

	always_comb begin
		case (resolve_op)
			OP_SEQ: begin
				flush_sel = flush_seq;
				redir_pc  = fall_thru;
			end
			OP_BRANCH: begin
				flush_sel = flush_br;
				redir_pc  = resolve_taken ? resolve_target : fall_thru;
			end
			OP_JUMP: begin
				flush_sel = flush_jmp;
				redir_pc  = resolve_target;
			end
			default: begin
				flush_sel = 1'b1;                          // no return stack
				redir_pc  = resolve_target;
			end
		endcase
	end

	assign redirect = resolve_valid && flush_sel;

	// **********************************************************************
	// next fetch address, exception first
	// **********************************************************************
	always_comb begin
		next_predict = 1'b0;
		if (exc) begin
			next_pc = EXC_VECTOR;
		end else if (eret) begin
			next_pc = epc;
		end else if (redirect) begin
			next_pc = redir_pc;
		end else if (pred_taken) begin
			next_pc      = pred_target;
			next_predict = 1'b1;
		end else begin
			next_pc = seq_pc;
		end
	end

	assign pf_flush = redirect || exc || eret;

endmodule

`default_nettype wire

/* src/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         stall,
	input  logic                         force_load,
	input  logic [fetch_pkg::ADDR_W-1:0] next_pc,
	input  logic                         next_predict,
	output logic [fetch_pkg::ADDR_W-1:0] fetch_pc,
	output logic                         fetch_predict,
	output logic [fetch_pkg::ADDR_W-1:0] seq_pc
);

	import fetch_pkg::*;

	logic pc_load;

	// redirects and exceptions get through a stall
	assign pc_load = !stall || force_load;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fetch_pc      <= RESET_PC;
			fetch_predict <= 1'b0;
		end else if (pc_load) begin
			fetch_pc      <= next_pc;
			fetch_predict <= next_predict;                 // stays with its pc
		end
	end

	assign seq_pc = fetch_pc + PC_STEP;

endmodule

`default_nettype wire

/* tb.f */
src/fetch_pkg.sv
src/branch_predictor.sv
src/next_pc_sel.sv
src/flush_ctrl.sv
src/pc_gen.sv
src/fetch_front.sv
tests/tb_clk_gen.sv
tests/fetch_front_props.sv
tests/tb_fetch_front.sv

/* tests/fetch_front_props.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_front_props (
	input logic                         clk,
	input logic                         arst_n,
	input logic                         exc,
	input logic                         can_go,
	input logic [fetch_pkg::ADDR_W-1:0] fetch_pc,
	input logic                         pf_flush,
	input logic                         if_flush,
	input logic                         id_flush,
	input logic                         ex_flush,
	input logic                         mem1_flush
);

	import fetch_pkg::*;

	rst_quiet: assert property (@(posedge clk)
		$rose(arst_n) |-> !(pf_flush || if_flush || id_flush || ex_flush || mem1_flush))
		else $error("flush active in the first cycle after reset release");

	exc_flushes: assert property (@(posedge clk) disable iff (!arst_n)
		exc |-> (if_flush && id_flush && ex_flush))
		else $error("exception without IF/ID/EX flush");

	// vector wins over stall and redirect
	exc_vector: assert property (@(posedge clk) disable iff (!arst_n)
		exc |=> (fetch_pc == EXC_VECTOR))
		else $error("fetch did not go to the exception vector");

	mem1_gated: assert property (@(posedge clk) disable iff (!arst_n)
		mem1_flush |-> can_go)
		else $error("memory stage flushed while it could not advance");

endmodule

bind fetch_front fetch_front_props u_props (.*);

`default_nettype wire

/* tests/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;                             // 8 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;                                    // release on an edge
	end

endmodule

`default_nettype wire

/* tests/tb_fetch_front.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_front;

	import fetch_pkg::*;

	localparam int N_RAND      = 400;
	localparam int STIM_CYCLES = 500;                      // directed part plus random run
	localparam int LIMIT       = 4 * STIM_CYCLES + 100;
	localparam logic [ADDR_W-1:0] BR_PC  = 32'hBFC0_0100;
	localparam logic [ADDR_W-1:0] BR_TGT = 32'hBFC0_0200;

	logic              clk;
	logic              arst_n;
	logic              resolve_valid;
	npc_op_t           resolve_op;
	logic [ADDR_W-1:0] resolve_pc;
	logic              resolve_taken;
	logic [ADDR_W-1:0] resolve_target;
	logic              resolve_predicted;
	logic [ADDR_W-1:0] resolve_pred_target;
	logic              exc;
	logic              eret;
	logic [ADDR_W-1:0] epc;
	logic              can_go;
	logic              stall;
	logic [ADDR_W-1:0] fetch_pc;
	logic              fetch_predict;
	logic              pf_flush;
	logic              if_flush;
	logic              id_flush;
	logic              ex_flush;
	logic              mem1_flush;
	int                seed;
	int                cyc = 0;
	int                n_predict = 0;
	int                n_redirect = 0;

	// reference model state
	logic [1:0]           m_cnt [BHT_ENTRIES];
	logic                 m_vld [BHT_ENTRIES];
	logic [BTB_TAG_W-1:0] m_tag [BHT_ENTRIES];
	logic [ADDR_W-1:0]    m_tgt [BHT_ENTRIES];
	logic [ADDR_W-1:0]    m_pc;
	logic                 m_pred;
	logic                 m_pend;

	tb_clk_gen u_clk (.clk(clk), .arst_n(arst_n));

	fetch_front DUT (.*);

	task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
			input logic [ADDR_W-1:0] act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
			$display("Simulation finished: FAIL");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %b got %b", $time, name, exp, act);
			$display("Simulation finished: FAIL");
			$fatal(1, "bit mismatch");
		end
	endtask

	function automatic logic mispredict(input npc_op_t op, input logic taken,
			input logic predicted, input logic [ADDR_W-1:0] tgt, input logic [ADDR_W-1:0] ptgt);
		case (op)
			OP_SEQ:    return predicted;
			OP_BRANCH: return (taken != predicted) || (taken && tgt != ptgt);
			OP_JUMP:   return !predicted || (tgt != ptgt);
			default:   return 1'b1;                        // every return redirects
		endcase
	endfunction

	// {predict, pc} loaded at the coming edge
	function automatic logic [ADDR_W:0] ref_next_pc(input logic redir, input logic ptaken,
			input logic [ADDR_W-1:0] ptgt, input logic [ADDR_W-1:0] cur_pc);
		if (exc) begin
			return {1'b0, EXC_VECTOR};
		end else if (eret) begin
			return {1'b0, epc};
		end else if (redir) begin
			if (resolve_op == OP_SEQ || (resolve_op == OP_BRANCH && !resolve_taken)) begin
				return {1'b0, resolve_pc + 32'd8};         // past the delay slot
			end
			return {1'b0, resolve_target};
		end else if (ptaken) begin
			return {1'b1, ptgt};
		end
		return {1'b0, cur_pc + 32'd4};
	endfunction

	// **********************************************************************
	// compare at the falling edge, then advance the model
	// **********************************************************************
	always @(negedge clk) begin : compare
		logic [BHT_IDX_W-1:0] li;
		logic [BHT_IDX_W-1:0] ui;
		logic                 ptaken;
		logic                 redir;
		logic                 exc_any;
		logic                 dir;
		logic [ADDR_W:0]      nxt;
		if (!arst_n) begin
			for (int i = 0; i < BHT_ENTRIES; i++) begin
				m_cnt[i] = 2'b01;
				m_vld[i] = 1'b0;
			end
			m_pc   = 32'hBFC0_0000;
			m_pred = 1'b0;
			m_pend = 1'b0;
		end else begin
			li      = m_pc[7:2];
			ptaken  = m_vld[li] && (m_tag[li] == m_pc[31:8]) && m_cnt[li][1];
			redir   = resolve_valid && mispredict(resolve_op, resolve_taken,
				resolve_predicted, resolve_target, resolve_pred_target);
			exc_any = exc || eret;
			check_addr("fetch_pc", m_pc, fetch_pc);
			check_bit("fetch_predict", m_pred, fetch_predict);
			check_bit("pf_flush", redir || exc_any, pf_flush);
			check_bit("if_flush", exc_any, if_flush);
			check_bit("id_flush", exc_any, id_flush);
			check_bit("ex_flush", exc_any, ex_flush);
			check_bit("mem1_flush", (exc_any || m_pend) && can_go, mem1_flush);
			if (fetch_predict) n_predict++;
			if (redir) n_redirect++;
			nxt = ref_next_pc(redir, ptaken, m_tgt[li], m_pc);
			if (!stall || redir || exc_any) begin
				m_pc   = nxt[ADDR_W-1:0];
				m_pred = nxt[ADDR_W];
			end
			if (can_go) m_pend = 1'b0;
			else if (exc_any) m_pend = 1'b1;
			if (resolve_valid && (resolve_op == OP_BRANCH || resolve_op == OP_JUMP)) begin
				ui  = resolve_pc[7:2];
				dir = resolve_taken || (resolve_op == OP_JUMP);
				if (dir && m_cnt[ui] != 2'b11) m_cnt[ui] = m_cnt[ui] + 2'd1;
				else if (!dir && m_cnt[ui] != 2'b00) m_cnt[ui] = m_cnt[ui] - 2'd1;
				if (dir) begin
					m_vld[ui] = 1'b1;
					m_tag[ui] = resolve_pc[31:8];
					m_tgt[ui] = resolve_target;
				end
			end
		end
	end

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc > LIMIT) begin
			$display("timeout after %0d cycles, stimulus never finished", cyc);
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic drive_idle();
		resolve_valid       <= 1'b0;
		resolve_op          <= OP_SEQ;
		resolve_pc          <= '0;
		resolve_taken       <= 1'b0;
		resolve_target      <= '0;
		resolve_predicted   <= 1'b0;
		resolve_pred_target <= '0;
		exc                 <= 1'b0;
		eret                <= 1'b0;
		epc                 <= '0;
		can_go              <= 1'b1;
		stall               <= 1'b0;
	endtask

	task automatic set_levels(input logic s, input logic g);
		@(posedge clk);
		stall  <= s;
		can_go <= g;
	endtask

	// one-cycle report from the back end
	task automatic send_report(input logic v, input npc_op_t op, input logic [ADDR_W-1:0] pc,
			input logic taken, input logic [ADDR_W-1:0] tgt, input logic predicted,
			input logic [ADDR_W-1:0] ptgt, input logic e, input logic r,
			input logic [ADDR_W-1:0] ret_pc);
		@(posedge clk);
		resolve_valid       <= v;
		resolve_op          <= op;
		resolve_pc          <= pc;
		resolve_taken       <= taken;
		resolve_target      <= tgt;
		resolve_predicted   <= predicted;
		resolve_pred_target <= ptgt;
		exc                 <= e;
		eret                <= r;
		epc                 <= ret_pc;
		@(posedge clk);
		resolve_valid <= 1'b0;
		exc           <= 1'b0;
		eret          <= 1'b0;
	endtask

	task automatic drive_random();
		logic [31:0]       r1;
		logic [31:0]       r2;
		logic [31:0]       r3;
		logic [ADDR_W-1:0] tgt;
		@(posedge clk);
		r1  = $random(seed);
		r2  = $random(seed);
		r3  = $random(seed);
		tgt = 32'hBFC0_0000 | (r3 & 32'h0000_01FC);        // small window, tags collide
		resolve_valid       <= r1[0];
		resolve_op          <= npc_op_t'(r1[2:1]);
		resolve_pc          <= 32'hBFC0_0000 | (r2 & 32'h0000_01FC);
		resolve_taken       <= r1[3];
		resolve_target      <= tgt;
		resolve_predicted   <= r1[4];
		resolve_pred_target <= r1[5] ? tgt : tgt + 32'd4;
		exc                 <= (r1[9:6] == 4'd0);
		eret                <= (r1[13:10] == 4'd0);
		epc                 <= 32'hBFC0_0000 | (r2 & 32'h0000_03FC);
		stall               <= r1[14] & r1[15];
		can_go              <= r1[16] | r1[17];
	endtask

	initial begin
		seed = 17741;
		drive_idle();
		@(posedge arst_n);
		repeat (6) @(posedge clk);                         // free running fetch
		set_levels(1'b1, 1'b1);
		repeat (4) @(posedge clk);
		set_levels(1'b0, 1'b1);
		// train, reach the branch, then weaken it below taken
		send_report(1, OP_BRANCH, BR_PC, 1, BR_TGT, 0, '0, 0, 0, '0);
		send_report(1, OP_BRANCH, BR_PC, 1, BR_TGT, 0, '0, 0, 0, '0);
		send_report(0, OP_SEQ, '0, 0, '0, 0, '0, 0, 1, BR_PC - 32'd8);
		repeat (4) @(posedge clk);
		send_report(1, OP_BRANCH, BR_PC, 0, BR_TGT, 1, BR_TGT, 0, 0, '0);
		send_report(1, OP_BRANCH, BR_PC, 0, BR_TGT, 1, BR_TGT, 0, 0, '0);
		send_report(0, OP_SEQ, '0, 0, '0, 0, '0, 0, 1, BR_PC - 32'd8);
		repeat (4) @(posedge clk);
		// each mispredict kind, then correct ones
		send_report(1, OP_SEQ, 32'hBFC0_0040, 0, '0, 1, 32'hBFC0_0080, 0, 0, '0);
		send_report(1, OP_BRANCH, 32'hBFC0_0060, 1, 32'hBFC0_0300, 0, '0, 0, 0, '0);
		send_report(1, OP_JUMP, 32'hBFC0_0070, 1, 32'hBFC0_0400, 1, 32'hBFC0_0404, 0, 0, '0);
		send_report(1, OP_RETURN, 32'hBFC0_0074, 1, 32'hBFC0_0500, 0, '0, 0, 0, '0);
		send_report(1, OP_BRANCH, 32'hBFC0_0090, 0, 32'hBFC0_0600, 0, '0, 0, 0, '0);
		send_report(1, OP_JUMP, 32'hBFC0_0070, 1, 32'hBFC0_0400, 1, 32'hBFC0_0400, 0, 0, '0);
		// exceptions against a stall and a mispredict
		set_levels(1'b1, 1'b1);
		send_report(1, OP_RETURN, 32'hBFC0_0020, 1, 32'hBFC0_0600, 0, '0, 1, 0, '0);
		send_report(1, OP_SEQ, 32'hBFC0_0024, 0, '0, 1, '0, 0, 1, 32'hBFC0_0700);
		set_levels(1'b0, 1'b0);
		send_report(0, OP_SEQ, '0, 0, '0, 0, '0, 1, 0, '0);
		repeat (3) @(posedge clk);                         // mem1 flush held back
		set_levels(1'b0, 1'b1);
		repeat (3) @(posedge clk);
		for (int i = 0; i < N_RAND; i++) begin
			drive_random();
		end
		@(posedge clk);
		drive_idle();
		repeat (3) @(posedge clk);
		if (n_predict == 0 || n_redirect == 0) begin
			$display("no predicted fetch or no redirect was seen during the run");
			$display("Simulation finished: FAIL");
			$fatal(1, "coverage hole");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
